/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hdl/decode_pkg.sv
      - hdl/inst_decoder.sv
      - hdl/reg_file.sv
      - hdl/operand_forward.sv
      - hdl/branch_unit.sv
      - hdl/decode_stage.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/decode_stage_tb.sv

/* bench/decode_stage_tb.sv */
`timescale 1ns/100ps

module decode_stage_tb import decode_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      fs_to_ds_valid;
    word_t     fs_inst;
    word_t     fs_pc;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    logic      es_fwd_valid;
    logic      es_blk_valid;
    reg_addr_t es_dest;
    word_t     es_data;
    logic      ms_fwd_valid;
    reg_addr_t ms_dest;
    word_t     ms_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    alu_op_t   alu_op;
    load_op_t  load_op;
    store_op_t store_op;
    logic      res_from_mem;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      gr_we;
    logic      mem_we;
    reg_addr_t dest;
    word_t     ds_imm;
    word_t     rj_value;
    word_t     rkd_value;
    word_t     ds_pc;
    logic      br_taken;
    logic      br_taken_cancel;
    word_t     br_target;

    // stimulus columns
    logic [7:0] s_ctrl [$];
    word_t      s_inst [$];
    word_t      s_pc [$];
    reg_addr_t  s_es_dest [$];
    word_t      s_es_data [$];
    reg_addr_t  s_ms_dest [$];
    word_t      s_ms_data [$];
    reg_addr_t  s_rf_waddr [$];
    word_t      s_rf_wdata [$];

    // expected columns
    logic [7:0]  e_mask [$];
    logic [11:0] e_flags [$];
    alu_op_t     e_alu [$];
    load_op_t    e_load [$];
    store_op_t   e_store [$];
    reg_addr_t   e_dest [$];
    word_t       e_imm [$];
    word_t       e_rj [$];
    word_t       e_rkd [$];
    word_t       e_pc [$];
    word_t       e_target [$];

    int n_records;
    int rec;
    int checks;
    int errors;
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    decode_stage u_dut (.*);

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h (record %0d)", name, exp, act, rec);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h (record %0d)", name, exp, act, rec);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h (record %0d)", name, exp, act, rec);
        end
    endtask

    task automatic check_alu_op(input alu_op_t exp, input alu_op_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail alu_op: expected %h, got %h (record %0d)", exp, act, rec);
        end
    endtask

    task automatic check_load_op(input load_op_t exp, input load_op_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail load_op: expected %h, got %h (record %0d)", exp, act, rec);
        end
    endtask

    task automatic check_store_op(input store_op_t exp, input store_op_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail store_op: expected %h, got %h (record %0d)", exp, act, rec);
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          code;
        string       line;
        bit          want_expect;
        logic [7:0]  ctrl;
        logic [11:0] flags;
        store_op_t   st;
        load_op_t    ld;
        alu_op_t     alu;
        reg_addr_t   a0, a1, a2;
        word_t       w0, w1, w2, w3, w4;
        word_t       w5;
        want_expect = 1'b0;
        fd = $fopen("bench/decode_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the test data file");
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 8 && line.getc(0) != "#") begin
                if (!want_expect) begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                   ctrl, w0, w1, a0, w2, a1, w3, a2, w4);
                    if (code != 9) begin
                        errors++;
                        $display("malformed stimulus line in the test data");
                    end
                    s_ctrl.push_back(ctrl);
                    s_inst.push_back(w0);
                    s_pc.push_back(w1);
                    s_es_dest.push_back(a0);
                    s_es_data.push_back(w2);
                    s_ms_dest.push_back(a1);
                    s_ms_data.push_back(w3);
                    s_rf_waddr.push_back(a2);
                    s_rf_wdata.push_back(w4);
                end else begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                   ctrl, flags, alu, ld, st, a0, w0, w1, w2, w3, w5);
                    if (code != 11) begin
                        errors++;
                        $display("malformed expected-value line in the test data");
                    end
                    e_mask.push_back(ctrl);
                    e_flags.push_back(flags);
                    e_alu.push_back(alu);
                    e_load.push_back(ld);
                    e_store.push_back(st);
                    e_dest.push_back(a0);
                    e_imm.push_back(w0);
                    e_rj.push_back(w1);
                    e_rkd.push_back(w2);
                    e_pc.push_back(w3);
                    e_target.push_back(w5);
                end
                want_expect = !want_expect;
            end
        end
        $fclose(fd);
        if (s_ctrl.size() != e_mask.size()) begin
            errors++;
            $display("test data has a stimulus line without expected values");
        end
        n_records = e_mask.size();
    endtask

    task automatic drive_record(input int i);
        fs_to_ds_valid = s_ctrl[i][0];
        es_allowin     = s_ctrl[i][1];
        es_fwd_valid   = s_ctrl[i][2];
        es_blk_valid   = s_ctrl[i][3];
        ms_fwd_valid   = s_ctrl[i][4];
        rf_we          = s_ctrl[i][5];
        fs_inst        = s_inst[i];
        fs_pc          = s_pc[i];
        es_dest        = s_es_dest[i];
        es_data        = s_es_data[i];
        ms_dest        = s_ms_dest[i];
        ms_data        = s_ms_data[i];
        rf_waddr       = s_rf_waddr[i];
        rf_wdata       = s_rf_wdata[i];
    endtask

    task automatic check_record(input int i);
        logic [7:0]  m;
        logic [11:0] f;
        m = e_mask[i];
        f = e_flags[i];
        if (m[0]) begin
            check_bit("ds_allowin", f[0], ds_allowin);
            check_bit("ds_to_es_valid", f[1], ds_to_es_valid);
            check_bit("br_taken", f[2], br_taken);
            check_bit("br_taken_cancel", f[3], br_taken_cancel);
        end
        if (m[1]) begin
            check_alu_op(e_alu[i], alu_op);
            check_load_op(e_load[i], load_op);
            check_store_op(e_store[i], store_op);
            check_bit("res_from_mem", f[4], res_from_mem);
            check_bit("src1_is_pc", f[5], src1_is_pc);
            check_bit("src2_is_imm", f[6], src2_is_imm);
            check_bit("gr_we", f[7], gr_we);
            check_bit("mem_we", f[8], mem_we);
            check_reg_addr("dest", e_dest[i], dest);
            check_word("ds_imm", e_imm[i], ds_imm);
            check_word("ds_pc", e_pc[i], ds_pc);
        end
        if (m[2]) begin
            check_word("rj_value", e_rj[i], rj_value);
        end
        if (m[3]) begin
            check_word("rkd_value", e_rkd[i], rkd_value);
        end
        if (m[4]) begin
            check_word("br_target", e_target[i], br_target);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        es_allowin     = 1'b0;
        es_fwd_valid   = 1'b0;
        es_blk_valid   = 1'b0;
        es_dest        = '0;
        es_data        = '0;
        ms_fwd_valid   = 1'b0;
        ms_dest        = '0;
        ms_data        = '0;
        rf_we          = 1'b0;
        rf_waddr       = '0;
        rf_wdata       = '0;
        checks         = 0;
        errors         = 0;
        n_records      = 0;
        load_testdata();
        cycle_limit = n_records * 2 + 20;
        // record k is driven after edge k and checked just before edge k+1
        for (rec = 0; rec < n_records; rec++) begin
            @(posedge clk);
            #1;
            drive_record(rec);
            #8;
            check_record(rec);
        end
        $display("records: %0d, checks: %0d, errors: %0d", n_records, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* bench/decode_testdata.txt */
# two lines per cycle, all hex. stimulus: ctrl inst pc es_dest es_data ms_dest ms_data rf_waddr rf_wdata
# ctrl bits: 0 fs_valid, 1 es_allowin, 2 es_fwd_valid, 3 es_blk_valid, 4 ms_fwd_valid, 5 rf_we
# expected: mask flags alu_op load_op store_op dest imm rj rkd ds_pc br_target
# mask: 0 handshake, 1 decode, 2 rj, 3 rkd, 4 target. flags: allowin valid taken cancel mem pc imm we st
# reset, fill r2 r3 r4
22 00000000 00000000 00 00000000 00 00000000 02 00000010
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
22 00000000 00000000 00 00000000 00 00000000 03 fffffff0
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
23 00100c46 1c000000 00 00000000 00 00000000 04 00000010
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
# add.w, addi.w, andi, lu12i.w, pcaddu12i, slli.w
03 02bffc47 1c000004 00 00000000 00 00000000 00 00000000
0f 083 001 00 0 06 00000403 00000010 fffffff0 1c000000 00000000
03 0363c068 1c000008 00 00000000 00 00000000 00 00000000
07 0c3 001 00 0 07 ffffffff 00000010 00000000 1c000004 00000000
03 15579bc9 1c00000c 00 00000000 00 00000000 00 00000000
07 0c3 010 00 0 08 000008f0 fffffff0 00000000 1c000008 00000000
03 1c00002a 1c000010 00 00000000 00 00000000 00 00000000
03 0c3 800 00 0 09 abcde000 00000000 00000000 1c00000c 00000000
03 00408c4b 1c000014 00 00000000 00 00000000 00 00000000
03 0e3 001 00 0 0a 00001000 00000000 00000000 1c000010 00000000
03 001108ac 1c000018 00 00000000 00 00000000 00 00000000
0f 0c3 100 00 0 0b 00000023 00000010 fffffff0 1c000014 00000000
# sub.w held by back-pressure, forwarding priority on r5
35 289fc04d 1c00001c 05 aaaa0001 05 bbbb0002 05 cccc0003
0f 082 002 00 0 0c 00000442 aaaa0001 00000010 1c000018 00000000
31 289fc04d 1c00001c 00 00000000 05 bbbb0002 05 dddd0004
0f 082 002 00 0 0c 00000442 bbbb0002 00000010 1c000018 00000000
21 289fc04d 1c00001c 00 00000000 00 00000000 05 eeee0005
0f 082 002 00 0 0c 00000442 eeee0005 00000010 1c000018 00000000
03 289fc04d 1c00001c 00 00000000 00 00000000 00 00000000
0f 083 002 00 0 0c 00000442 eeee0005 00000010 1c000018 00000000
# ld.w, ld.bu, st.h with r0 base
03 2a3ff06e 1c000020 00 00000000 00 00000000 00 00000000
07 0d3 001 04 0 0d 000007f0 00000010 00000000 1c00001c 00000000
03 29404004 1c000024 00 00000000 00 00000000 00 00000000
07 0d3 001 08 0 0e fffffffc fffffff0 00000000 1c000020 00000000
07 001509af 1c000028 00 deadbeef 00 00000000 00 00000000
0f 143 001 00 2 04 00000010 00000000 00000010 1c000024 00000000
# load-use stall on r13 for two cycles
0f 58004044 1c00002c 0d 12345678 00 00000000 00 00000000
03 080 040 00 0 0f 00000542 00000000 00000000 1c000028 00000000
0f 58004044 1c00002c 0d 12345678 00 00000000 00 00000000
03 080 040 00 0 0f 00000542 00000000 00000000 1c000028 00000000
13 58004044 1c00002c 00 00000000 0d 0000abcd 00 00000000
0f 083 040 00 0 0f 00000542 0000abcd 00000010 1c000028 00000000
# beq taken, then one empty cycle
03 00000000 1c000030 00 00000000 00 00000000 00 00000000
1f 00f 000 00 0 04 00000010 00000010 00000010 1c00002c 1c00006c
03 5ffff844 1c00006c 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
# bne not taken
03 60040062 1c000070 00 00000000 00 00000000 00 00000000
1f 003 000 00 0 04 fffffffe 00000010 00000010 1c00006c 1c000064
# blt taken under back-pressure, cancels once execute accepts
01 00000000 1c000074 00 00000000 00 00000000 00 00000000
1f 006 000 00 0 02 00000100 fffffff0 00000010 1c000070 1c000470
03 00000000 1c000074 00 00000000 00 00000000 00 00000000
1f 00f 000 00 0 02 00000100 fffffff0 00000010 1c000070 1c000470
03 68001062 1c000470 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
# bltu not taken, bgeu taken backwards
03 6ffffc62 1c000474 00 00000000 00 00000000 00 00000000
1f 003 000 00 0 02 00000004 fffffff0 00000010 1c000470 1c000480
03 00000000 1c000478 00 00000000 00 00000000 00 00000000
1f 00f 000 00 0 02 ffffffff fffffff0 00000010 1c000474 1c000470
03 64002062 1c000470 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
# bge not taken, bl
03 54040000 1c000474 00 00000000 00 00000000 00 00000000
1f 003 000 00 0 02 00000008 fffffff0 00000010 1c000470 1c000490
03 00000000 1c000478 00 00000000 00 00000000 00 00000000
1f 0ef 001 00 0 01 00000004 00000000 00000000 1c000474 1c000874
03 4c002041 1c000874 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
# jirl off a forwarded r2, then b backwards
13 00000000 1c000878 00 00000000 02 00001000 00 00000000
17 0ef 001 00 0 01 00000004 00001000 00000000 1c000874 00001020
03 53fffbff 00001020 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
03 00000000 00001024 00 00000000 00 00000000 00 00000000
13 00f 000 00 0 1f fffffffe 00000000 00000000 00001020 00001018
02 00000000 00000000 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000
02 00000000 00000000 00 00000000 00 00000000 00 00000000
01 001 000 00 0 00 00000000 00000000 00000000 00000000 00000000

/* bench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // released on the third rising edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/100ps

module branch_unit import decode_pkg::*; (
    input  logic [5:0] br_cond,
    input  logic       br_uncond,
    input  logic       br_reg_based,
    input  word_t      rj_value,
    input  word_t      rkd_value,
    input  word_t      pc,
    input  word_t      inst,
    output logic       taken,
    output word_t      target
);

    logic [xlen:0] diff;
    logic          eq;
    logic          lt;
    logic          ltu;
    logic [5:0]    cond_met;
    logic [15:0]   offs16;
    logic [25:0]   offs26;
    word_t         offset;
    word_t         base;

    // rj - rkd with a carry-out bit
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 1'b1;
    assign eq   = (diff[xlen-1:0] == '0);
    assign ltu  = !diff[xlen];
    assign lt   = (rj_value[xlen-1] && !rkd_value[xlen-1])
                || (!(rj_value[xlen-1] ^ rkd_value[xlen-1]) && diff[xlen-1]);

    assign cond_met[br_eq]  = eq;
    assign cond_met[br_ne]  = !eq;
    assign cond_met[br_lt]  = lt;
    assign cond_met[br_ge]  = !lt;
    assign cond_met[br_ltu] = ltu;
    assign cond_met[br_geu] = !ltu;

    assign taken = br_uncond || (|(br_cond & cond_met));

    assign offs16 = inst[25:10];
    assign offs26 = {inst[9:0], inst[25:10]};

    // b and bl carry the long offset
    assign offset = (br_uncond && !br_reg_based)
                  ? {{(xlen-28){offs26[25]}}, offs26, 2'b00}
                  : {{(xlen-18){offs16[15]}}, offs16, 2'b00};

    assign base   = br_reg_based ? rj_value : pc;
    assign target = base + offset;

endmodule

/* hdl/decode_pkg.sv */
package decode_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    typedef logic [xlen-1:0]              word_t;
    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

    // one-hot control fields
    typedef logic [11:0] alu_op_t;
    typedef logic [4:0]  load_op_t;
    typedef logic [2:0]  store_op_t;

    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    localparam int load_b  = 0;
    localparam int load_h  = 1;
    localparam int load_w  = 2;
    localparam int load_bu = 3;
    localparam int load_hu = 4;

    localparam int store_b = 0;
    localparam int store_h = 1;
    localparam int store_w = 2;

    // bit positions of the branch condition vector
    localparam int br_eq  = 0;
    localparam int br_ne  = 1;
    localparam int br_lt  = 2;
    localparam int br_ge  = 3;
    localparam int br_ltu = 4;
    localparam int br_geu = 5;

    // inst[31:26]
    localparam logic [5:0] op6_alu         = 6'h00;
    localparam logic [5:0] op6_lu12i       = 6'h05;
    localparam logic [5:0] op6_pcaddu12i   = 6'h07;
    localparam logic [5:0] op6_mem         = 6'h0a;
    localparam logic [5:0] op6_jirl        = 6'h13;
    localparam logic [5:0] op6_b           = 6'h14;
    localparam logic [5:0] op6_bl          = 6'h15;
    localparam logic [5:0] op6_branch_beq  = 6'h16;
    localparam logic [5:0] op6_branch_bne  = 6'h17;
    localparam logic [5:0] op6_branch_blt  = 6'h18;
    localparam logic [5:0] op6_branch_bge  = 6'h19;
    localparam logic [5:0] op6_branch_bltu = 6'h1a;
    localparam logic [5:0] op6_branch_bgeu = 6'h1b;

    // inst[25:22] under op6_alu
    localparam logic [3:0] op4_alu_reg   = 4'h0;
    localparam logic [3:0] op4_alu_shift = 4'h1;
    localparam logic [3:0] op4_slti      = 4'h8;
    localparam logic [3:0] op4_sltui     = 4'h9;
    localparam logic [3:0] op4_addi      = 4'ha;
    localparam logic [3:0] op4_andi      = 4'hd;
    localparam logic [3:0] op4_ori       = 4'he;
    localparam logic [3:0] op4_xori      = 4'hf;

    // inst[25:22] under op6_mem
    localparam logic [3:0] op4_ld_b  = 4'h0;
    localparam logic [3:0] op4_ld_h  = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_b  = 4'h4;
    localparam logic [3:0] op4_st_h  = 4'h5;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_ld_bu = 4'h8;
    localparam logic [3:0] op4_ld_hu = 4'h9;

    // inst[21:20]
    localparam logic [1:0] op2_alu_reg   = 2'h1;
    localparam logic [1:0] op2_alu_shift = 2'h0;

    // inst[19:15], three-register forms
    localparam logic [4:0] op5_add_w = 5'h00;
    localparam logic [4:0] op5_sub_w = 5'h02;
    localparam logic [4:0] op5_slt   = 5'h04;
    localparam logic [4:0] op5_sltu  = 5'h05;
    localparam logic [4:0] op5_nor   = 5'h08;
    localparam logic [4:0] op5_and   = 5'h09;
    localparam logic [4:0] op5_or    = 5'h0a;
    localparam logic [4:0] op5_xor   = 5'h0b;
    localparam logic [4:0] op5_sll_w = 5'h0e;
    localparam logic [4:0] op5_srl_w = 5'h0f;
    localparam logic [4:0] op5_sra_w = 5'h10;

    // inst[19:15], shift-immediate forms
    localparam logic [4:0] op5_slli_w = 5'h01;
    localparam logic [4:0] op5_srli_w = 5'h09;
    localparam logic [4:0] op5_srai_w = 5'h11;

    localparam reg_addr_t link_reg    = 5'd1;
    localparam word_t     link_offset = 32'd4;

endpackage

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  word_t     fs_inst,
    input  word_t     fs_pc,
    output logic      ds_allowin,
    input  logic      es_allowin,
    output logic      ds_to_es_valid,
    input  logic      es_fwd_valid,
    input  logic      es_blk_valid,
    input  reg_addr_t es_dest,
    input  word_t     es_data,
    input  logic      ms_fwd_valid,
    input  reg_addr_t ms_dest,
    input  word_t     ms_data,
    input  logic      rf_we,
    input  reg_addr_t rf_waddr,
    input  word_t     rf_wdata,
    output alu_op_t   alu_op,
    output load_op_t  load_op,
    output store_op_t store_op,
    output logic      res_from_mem,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output logic      gr_we,
    output logic      mem_we,
    output reg_addr_t dest,
    output word_t     ds_imm,
    output word_t     rj_value,
    output word_t     rkd_value,
    output word_t     ds_pc,
    output logic      br_taken,
    output logic      br_taken_cancel,
    output word_t     br_target
);

    logic       ds_valid;
    logic       ds_ready_go;
    logic       load_use;
    word_t      ds_inst;
    reg_addr_t  raddr1;
    reg_addr_t  raddr2;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    logic [5:0] br_cond;
    logic       br_uncond;
    logic       br_reg_based;
    logic       bu_taken;

    // load in execute has no data yet
    assign load_use = es_blk_valid && (es_dest != '0)
                    && ((es_dest == raddr1) || (es_dest == raddr2));

    assign ds_ready_go    = !load_use;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign br_taken        = bu_taken && ds_to_es_valid;
    assign br_taken_cancel = br_taken && es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_taken_cancel) begin
            // drop the instruction fetched behind the branch
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder u_inst_decoder (
        .inst         (ds_inst),
        .alu_op       (alu_op),
        .load_op      (load_op),
        .store_op     (store_op),
        .res_from_mem (res_from_mem),
        .mem_we       (mem_we),
        .gr_we        (gr_we),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .dest         (dest),
        .imm          (ds_imm),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .br_cond      (br_cond),
        .br_uncond    (br_uncond),
        .br_reg_based (br_reg_based)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (raddr2),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    operand_forward u_fwd_rj (
        .raddr        (raddr1),
        .es_fwd_valid (es_fwd_valid),
        .ms_fwd_valid (ms_fwd_valid),
        .rf_we        (rf_we),
        .es_dest      (es_dest),
        .ms_dest      (ms_dest),
        .rf_waddr     (rf_waddr),
        .es_data      (es_data),
        .ms_data      (ms_data),
        .rf_wdata     (rf_wdata),
        .rf_rdata     (rf_rdata1),
        .value        (rj_value)
    );

    // second source is rk, or rd for stores and branches
    operand_forward u_fwd_rkd (
        .raddr        (raddr2),
        .es_fwd_valid (es_fwd_valid),
        .ms_fwd_valid (ms_fwd_valid),
        .rf_we        (rf_we),
        .es_dest      (es_dest),
        .ms_dest      (ms_dest),
        .rf_waddr     (rf_waddr),
        .es_data      (es_data),
        .ms_data      (ms_data),
        .rf_wdata     (rf_wdata),
        .rf_rdata     (rf_rdata2),
        .value        (rkd_value)
    );

    branch_unit u_branch_unit (
        .br_cond      (br_cond),
        .br_uncond    (br_uncond),
        .br_reg_based (br_reg_based),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .pc           (ds_pc),
        .inst         (ds_inst),
        .taken        (bu_taken),
        .target       (br_target)
    );

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder import decode_pkg::*; (
    input  word_t     inst,
    output alu_op_t   alu_op,
    output load_op_t  load_op,
    output store_op_t store_op,
    output logic      res_from_mem,
    output logic      mem_we,
    output logic      gr_we,
    output logic      src1_is_pc,
    output logic      src2_is_imm,
    output reg_addr_t dest,
    output word_t     imm,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output logic [5:0] br_cond,
    output logic      br_uncond,
    output logic      br_reg_based
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;

    logic alu_grp;
    logic mem_grp;
    logic reg3;
    logic shift_imm;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_nor, inst_and, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui;
    logic inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_pcaddu12i;
    logic inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
    logic inst_st_b, inst_st_h, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;

    logic is_store;
    logic is_cond_br;
    logic need_ui12;
    logic need_i20;
    logic src2_is_4;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i20 = inst[24:5];

    assign alu_grp   = (op6 == op6_alu);
    assign mem_grp   = (op6 == op6_mem);
    assign reg3      = alu_grp && (op4 == op4_alu_reg) && (op2 == op2_alu_reg);
    assign shift_imm = alu_grp && (op4 == op4_alu_shift) && (op2 == op2_alu_shift);

    assign inst_add_w  = reg3 && (op5 == op5_add_w);
    assign inst_sub_w  = reg3 && (op5 == op5_sub_w);
    assign inst_slt    = reg3 && (op5 == op5_slt);
    assign inst_sltu   = reg3 && (op5 == op5_sltu);
    assign inst_nor    = reg3 && (op5 == op5_nor);
    assign inst_and    = reg3 && (op5 == op5_and);
    assign inst_or     = reg3 && (op5 == op5_or);
    assign inst_xor    = reg3 && (op5 == op5_xor);
    assign inst_sll_w  = reg3 && (op5 == op5_sll_w);
    assign inst_srl_w  = reg3 && (op5 == op5_srl_w);
    assign inst_sra_w  = reg3 && (op5 == op5_sra_w);
    assign inst_slli_w = shift_imm && (op5 == op5_slli_w);
    assign inst_srli_w = shift_imm && (op5 == op5_srli_w);
    assign inst_srai_w = shift_imm && (op5 == op5_srai_w);

    assign inst_addi_w = alu_grp && (op4 == op4_addi);
    assign inst_slti   = alu_grp && (op4 == op4_slti);
    assign inst_sltui  = alu_grp && (op4 == op4_sltui);
    assign inst_andi   = alu_grp && (op4 == op4_andi);
    assign inst_ori    = alu_grp && (op4 == op4_ori);
    assign inst_xori   = alu_grp && (op4 == op4_xori);

    // bit 25 set selects other 1RI20 forms
    assign inst_lu12i_w   = (op6 == op6_lu12i) && !inst[25];
    assign inst_pcaddu12i = (op6 == op6_pcaddu12i) && !inst[25];

    assign inst_ld_b  = mem_grp && (op4 == op4_ld_b);
    assign inst_ld_h  = mem_grp && (op4 == op4_ld_h);
    assign inst_ld_w  = mem_grp && (op4 == op4_ld_w);
    assign inst_ld_bu = mem_grp && (op4 == op4_ld_bu);
    assign inst_ld_hu = mem_grp && (op4 == op4_ld_hu);
    assign inst_st_b  = mem_grp && (op4 == op4_st_b);
    assign inst_st_h  = mem_grp && (op4 == op4_st_h);
    assign inst_st_w  = mem_grp && (op4 == op4_st_w);

    assign inst_jirl = (op6 == op6_jirl);
    assign inst_b    = (op6 == op6_b);
    assign inst_bl   = (op6 == op6_bl);

    assign br_cond[br_eq]  = (op6 == op6_branch_beq);
    assign br_cond[br_ne]  = (op6 == op6_branch_bne);
    assign br_cond[br_lt]  = (op6 == op6_branch_blt);
    assign br_cond[br_ge]  = (op6 == op6_branch_bge);
    assign br_cond[br_ltu] = (op6 == op6_branch_bltu);
    assign br_cond[br_geu] = (op6 == op6_branch_bgeu);
    assign br_uncond       = inst_b || inst_bl || inst_jirl;
    assign br_reg_based    = inst_jirl;

    assign load_op[load_b]  = inst_ld_b;
    assign load_op[load_h]  = inst_ld_h;
    assign load_op[load_w]  = inst_ld_w;
    assign load_op[load_bu] = inst_ld_bu;
    assign load_op[load_hu] = inst_ld_hu;

    assign store_op[store_b] = inst_st_b;
    assign store_op[store_h] = inst_st_h;
    assign store_op[store_w] = inst_st_w;

    assign res_from_mem = |load_op;
    assign is_store     = |store_op;
    assign is_cond_br   = |br_cond;

    // address generation and link values go through the adder
    assign alu_op[alu_add]  = inst_add_w || inst_addi_w || res_from_mem || is_store
                            || inst_jirl || inst_bl || inst_pcaddu12i;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt || inst_slti;
    assign alu_op[alu_sltu] = inst_sltu || inst_sltui;
    assign alu_op[alu_and]  = inst_and || inst_andi;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or || inst_ori;
    assign alu_op[alu_xor]  = inst_xor || inst_xori;
    assign alu_op[alu_sll]  = inst_sll_w || inst_slli_w;
    assign alu_op[alu_srl]  = inst_srl_w || inst_srli_w;
    assign alu_op[alu_sra]  = inst_sra_w || inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    assign need_ui12 = inst_andi || inst_ori || inst_xori;
    assign need_i20  = inst_lu12i_w || inst_pcaddu12i;
    assign src2_is_4 = inst_bl || inst_jirl;

    // shift amounts sit in the low bits of si12
    always_comb begin
        if (src2_is_4) begin
            imm = link_offset;
        end else if (need_i20) begin
            imm = {i20, 12'b0};
        end else if (need_ui12) begin
            imm = {{(xlen-12){1'b0}}, i12};
        end else begin
            imm = {{(xlen-12){i12[11]}}, i12};
        end
    end

    assign src1_is_pc  = inst_jirl || inst_bl || inst_pcaddu12i;
    assign src2_is_imm = shift_imm || inst_addi_w || inst_slti || inst_sltui
                       || need_ui12 || need_i20 || res_from_mem || is_store || src2_is_4;

    assign mem_we = is_store;
    assign gr_we  = !(is_store || is_cond_br || inst_b);
    assign dest   = inst_bl ? link_reg : rd;

    assign raddr1 = rj;
    assign raddr2 = (is_cond_br || is_store) ? rd : rk;

endmodule

/* hdl/operand_forward.sv */
`timescale 1ns/100ps

module operand_forward import decode_pkg::*; (
    input  reg_addr_t raddr,
    input  logic      es_fwd_valid,
    input  logic      ms_fwd_valid,
    input  logic      rf_we,
    input  reg_addr_t es_dest,
    input  reg_addr_t ms_dest,
    input  reg_addr_t rf_waddr,
    input  word_t     es_data,
    input  word_t     ms_data,
    input  word_t     rf_wdata,
    input  word_t     rf_rdata,
    output word_t     value
);

    logic es_hit;
    logic ms_hit;
    logic ws_hit;

    assign es_hit = es_fwd_valid && (es_dest == raddr);
    assign ms_hit = ms_fwd_valid && (ms_dest == raddr);
    assign ws_hit = rf_we && (rf_waddr == raddr);

    // youngest producer wins
    always_comb begin
        if (raddr == '0) begin
            value = '0;
        end else if (es_hit) begin
            value = es_data;
        end else if (ms_hit) begin
            value = ms_data;
        end else if (ws_hit) begin
            value = rf_wdata;
        end else begin
            value = rf_rdata;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file import decode_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    output word_t     rdata1,
    input  reg_addr_t raddr2,
    output word_t     rdata2,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    word_t regs [0:reg_count-1];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, its storage is never read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* list.f */
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/decode_stage.sv
bench/tb_clock_gen.sv
bench/decode_stage_tb.sv
